// File: include/tx_config.svh
`ifndef TX_CONFIG_SVH
`define TX_CONFIG_SVH

// packet geometry
`define TX_SEG_BYTES       16 // payload bytes per segment
`define TX_SEGS_PER_FRAME  4
`define TX_TAG_BYTES       4  // txid, segment, repeat, flags

// phy reset hold, ready after 2**(bits-1) cycles
`define TX_PHY_RST_BITS    6

// frame buffer, TX_SEGS_PER_FRAME * TX_SEG_BYTES entries
`define TX_BUF_ADDR_BITS   6

`endif

// File: rtl/link_pkg.sv
package link_pkg;

	// negotiated link rate, encoding follows the speed select of the board
	typedef enum logic [1:0] {
		speed_none = 2'b00, // no link, pacing stopped
		speed_10   = 2'b01,
		speed_100  = 2'b10,
		speed_1000 = 2'b11
	} link_speed_e;

endpackage

// File: rtl/eth_frame_pkg.sv
package eth_frame_pkg;

	localparam int TAG_FIELD_BITS = 8;
	localparam int TAG_FIELDS     = 4;
	localparam int TAG_FLAG_LAST  = 0; // flags bit, last segment of the frame

	typedef struct packed {
		logic [TAG_FIELD_BITS-1:0] txid;        // frame id
		logic [TAG_FIELD_BITS-1:0] segment_num;
		logic [TAG_FIELD_BITS-1:0] repeat_num;  // copy of the segment
		logic [TAG_FIELD_BITS-1:0] flags;
	} seg_tag_fields_t;

	// same word as fields or as bytes, byte 3 goes out first
	typedef union packed {
		seg_tag_fields_t                            f;
		logic [TAG_FIELDS-1:0][TAG_FIELD_BITS-1:0] b;
	} seg_tag_u;

endpackage

// File: rtl/tx_timing.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_timing
	import link_pkg::*;
(
	input  logic        clk125MHz,
	input  logic        rst_with_vio,
	input  link_speed_e link_speed,
	output logic        advance,
	output logic        phy_ready,
	output logic        eth_rst_b
);

	localparam int PACE_BITS = 7; // holds 0..99

	logic [PACE_BITS-1:0]        pace_cnt;
	logic [PACE_BITS-1:0]        pace_limit;
	link_speed_e                 speed_q;
	logic [`TX_PHY_RST_BITS-1:0] phy_cnt;

	// =========================================================================
	// byte pacing
	// =========================================================================
	always_comb begin
		unique case (link_speed)
			speed_10:  pace_limit = PACE_BITS'(99); // one byte per 100 clocks
			speed_100: pace_limit = PACE_BITS'(9);
			default:   pace_limit = '0; // gigabit, every clock
		endcase
	end

	always_ff @(posedge clk125MHz) begin
		if (rst_with_vio) begin
			pace_cnt <= '0;
			speed_q  <= speed_none;
			advance  <= 1'b0;
		end else begin
			speed_q <= link_speed;
			// restart the divider whenever the rate changes
			if (link_speed != speed_q || pace_cnt >= pace_limit)
				pace_cnt <= '0;
			else
				pace_cnt <= pace_cnt + 1'b1;
			advance <= (link_speed != speed_none) && (link_speed == speed_q) &&
				(pace_cnt == '0);
		end
	end

	// =========================================================================
	// phy reset hold
	// =========================================================================
	always_ff @(posedge clk125MHz) begin
		if (rst_with_vio)
			phy_cnt <= '0;
		else if (!phy_cnt[`TX_PHY_RST_BITS-1])
			phy_cnt <= phy_cnt + 1'b1; // saturates once top bit sets
	end

	assign eth_rst_b = phy_cnt[`TX_PHY_RST_BITS-1]; // active low phy reset
	assign phy_ready = phy_cnt[`TX_PHY_RST_BITS-1];

endmodule

// File: rtl/send_control.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module send_control
	import eth_frame_pkg::*;
(
	input  logic       clk125MHz,
	input  logic       rst_with_vio,
	input  logic       frame_done,
	input  logic       phy_ready,
	input  logic       busy,
	input  logic [7:0] redundancy,
	output logic       start_sending,
	output seg_tag_u   seg_tag,
	output logic       frame_sent
);

	typedef enum logic [1:0] {
		st_idle,
		st_launch,   // start pulse for one packet
		st_wait_pkt, // packet builder running
		st_next      // frame finished, bump txid
	} state_t;

	state_t     state;
	logic [7:0] txid;
	logic [7:0] seg_cnt;
	logic [7:0] rep_cnt;
	logic       last_seg;

	assign last_seg = (seg_cnt == 8'(`TX_SEGS_PER_FRAME - 1));

	// =========================================================================
	// segment / repeat sequencing
	// =========================================================================
	always_ff @(posedge clk125MHz) begin
		if (rst_with_vio) begin
			state   <= st_idle;
			txid    <= '0;
			seg_cnt <= '0;
			rep_cnt <= '0;
		end else begin
			unique case (state)
				st_idle: begin
					// frames arriving before the phy is up are dropped
					if (frame_done && phy_ready) begin
						seg_cnt <= '0;
						rep_cnt <= '0;
						state   <= st_launch;
					end
				end
				st_launch: state <= st_wait_pkt;
				st_wait_pkt: begin
					if (!busy) begin
						if (rep_cnt >= redundancy) begin
							rep_cnt <= '0;
							if (last_seg) begin
								state <= st_next;
							end else begin
								seg_cnt <= seg_cnt + 1'b1;
								state   <= st_launch;
							end
						end else begin
							rep_cnt <= rep_cnt + 1'b1; // same segment again
							state   <= st_launch;
						end
					end
				end
				st_next: begin
					txid    <= txid + 1'b1;
					seg_cnt <= '0;
					state   <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign start_sending = (state == st_launch);
	assign frame_sent    = (state == st_next);

	// tag only moves after busy has dropped, so it holds for the whole packet
	always_comb begin
		seg_tag.f.txid        = txid;
		seg_tag.f.segment_num = seg_cnt;
		seg_tag.f.repeat_num  = rep_cnt;
		seg_tag.f.flags       = '0;
		seg_tag.f.flags[TAG_FLAG_LAST] = last_seg;
	end

endmodule

// File: rtl/segment_buffer.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module segment_buffer (
	input  logic                         clk125MHz,
	input  logic                         wr_en,
	input  logic [`TX_BUF_ADDR_BITS-1:0] wr_addr,
	input  logic [7:0]                   wr_data,
	input  logic [`TX_BUF_ADDR_BITS-1:0] rd_addr,
	output logic [7:0]                   rd_data
);

	localparam int DEPTH = `TX_SEGS_PER_FRAME * `TX_SEG_BYTES;

	logic [7:0] mem [DEPTH]; // whole frame, segment after segment

	// frame writer side
	always_ff @(posedge clk125MHz) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, data one clock after the address
	always_ff @(posedge clk125MHz) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: rtl/byte_data.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module byte_data
	import eth_frame_pkg::*;
(
	input  logic                         clk125MHz,
	input  logic                         rst_with_vio,
	input  logic                         start,
	input  logic                         advance,
	input  seg_tag_u                     seg_tag,
	input  logic [7:0]                   rd_data,
	output logic [`TX_BUF_ADDR_BITS-1:0] rd_addr,
	output logic                         busy,
	output logic [7:0]                   data,
	output logic                         data_valid,
	output logic                         data_enable
);

	localparam int PKT_BYTES = `TX_TAG_BYTES + `TX_SEG_BYTES;
	localparam int CNT_BITS  = $clog2(PKT_BYTES + 1);

	logic [CNT_BITS-1:0] byte_cnt;
	logic [CNT_BITS-1:0] payload_idx;
	logic [1:0]          tag_idx;
	logic                in_tag;
	logic                fire;        // this strobe emits a byte
	logic                last_issued;
	logic                payload_q;   // byte on the output comes from the buffer
	logic [7:0]          tag_byte_q;

	assign in_tag      = (byte_cnt < CNT_BITS'(`TX_TAG_BYTES));
	assign tag_idx     = 2'(`TX_TAG_BYTES - 1 - byte_cnt); // byte 3 first
	assign payload_idx = byte_cnt - CNT_BITS'(`TX_TAG_BYTES);

	// address from the tag, segment base plus offset in the segment
	assign rd_addr = `TX_BUF_ADDR_BITS'(seg_tag.f.segment_num * `TX_SEG_BYTES) +
		`TX_BUF_ADDR_BITS'(payload_idx);

	assign fire = busy && advance && !last_issued;

	// =========================================================================
	// packet sequencing
	// =========================================================================
	always_ff @(posedge clk125MHz) begin
		if (rst_with_vio) begin
			busy        <= 1'b0;
			byte_cnt    <= '0;
			last_issued <= 1'b0;
			data_valid  <= 1'b0;
			data_enable <= 1'b0;
		end else begin
			data_valid <= fire;
			if (start && !busy) begin
				busy     <= 1'b1;
				byte_cnt <= '0;
			end else if (last_issued) begin
				// last byte is on the output now
				busy        <= 1'b0;
				last_issued <= 1'b0;
				data_enable <= 1'b0;
			end else if (fire) begin
				data_enable <= 1'b1;
				byte_cnt    <= byte_cnt + 1'b1;
				if (byte_cnt == CNT_BITS'(PKT_BYTES - 1))
					last_issued <= 1'b1;
			end
		end
	end

	// byte select, lines up with the buffer read latency
	always_ff @(posedge clk125MHz) begin
		if (fire) begin
			payload_q  <= !in_tag;
			tag_byte_q <= seg_tag.b[tag_idx];
		end
	end

	assign data = payload_q ? rd_data : tag_byte_q;

endmodule

// File: rtl/hdmi_eth_tx_top.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module hdmi_eth_tx_top
	import link_pkg::*;
	import eth_frame_pkg::*;
(
	input  logic                         clk125MHz,
	input  logic                         rst_with_vio,
	input  link_speed_e                  link_speed,
	input  logic [7:0]                   redundancy, // extra copies per segment
	input  logic                         frame_done,
	input  logic                         wr_en,
	input  logic [`TX_BUF_ADDR_BITS-1:0] wr_addr,
	input  logic [7:0]                   wr_data,
	output logic                         eth_rst_b,
	output logic                         phy_ready,
	output logic [7:0]                   tx_data,
	output logic                         tx_valid,
	output logic                         tx_enable,
	output logic                         tx_busy,
	output logic                         frame_sent
);

	logic                         advance;
	logic                         start_sending;
	seg_tag_u                     seg_tag;
	logic [`TX_BUF_ADDR_BITS-1:0] rd_addr;
	logic [7:0]                   rd_data;

	// =========================================================================
	// pacing and phy reset
	// =========================================================================
	tx_timing u_tx_timing (
		.clk125MHz   (clk125MHz),
		.rst_with_vio(rst_with_vio),
		.link_speed  (link_speed),
		.advance     (advance),
		.phy_ready   (phy_ready),
		.eth_rst_b   (eth_rst_b)
	);

	// =========================================================================
	// frame sequencing
	// =========================================================================
	send_control u_send_control (
		.clk125MHz    (clk125MHz),
		.rst_with_vio (rst_with_vio),
		.frame_done   (frame_done),
		.phy_ready    (phy_ready),
		.busy         (tx_busy),
		.redundancy   (redundancy),
		.start_sending(start_sending),
		.seg_tag      (seg_tag),
		.frame_sent   (frame_sent)
	);

	segment_buffer u_segment_buffer (
		.clk125MHz(clk125MHz),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	byte_data u_byte_data (
		.clk125MHz   (clk125MHz),
		.rst_with_vio(rst_with_vio),
		.start       (start_sending),
		.advance     (advance),
		.seg_tag     (seg_tag),
		.rd_data     (rd_data),
		.rd_addr     (rd_addr),
		.busy        (tx_busy),
		.data        (tx_data),
		.data_valid  (tx_valid),
		.data_enable (tx_enable)
	);

endmodule

// File: dv/tx_checker.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module tx_checker
	import link_pkg::*;
(
	input  logic                                             clk125MHz,
	input  logic                                             rst_with_vio,
	input  link_speed_e                                      link_speed,
	input  logic [7:0]                                       redundancy,
	input  logic [`TX_SEGS_PER_FRAME*`TX_SEG_BYTES-1:0][7:0] buf_copy,
	input  logic                                             eth_rst_b,
	input  logic                                             phy_ready,
	input  logic [7:0]                                       tx_data,
	input  logic                                             tx_valid,
	input  logic                                             tx_enable,
	input  logic                                             tx_busy,
	input  logic                                             frame_sent,
	output int                                               checks,
	output int                                               mismatches,
	output int                                               other_errors
);

	localparam int PKT_BYTES  = `TX_TAG_BYTES + `TX_SEG_BYTES;
	localparam int PHY_CYCLES = 2 ** (`TX_PHY_RST_BITS - 1); // phy hold after reset

	int   exp_txid;
	int   exp_seg;
	int   exp_rep;
	int   byte_idx;   // position inside the current packet
	int   cyc;
	int   last_cyc;
	logic frame_complete;
	logic drop_due;   // last byte just seen, busy low now
	logic sent_due;   // frame_sent expected on this sample

	// expected byte: tag fields first, then the segment's slice of the buffer
	function automatic logic [7:0] ref_byte(input int txid, input int seg, input int rep,
		input int idx);
		case (idx)
			0: return 8'(txid);
			1: return 8'(seg);
			2: return 8'(rep);
			3: return {7'd0, seg == `TX_SEGS_PER_FRAME - 1}; // last segment flag
			default: return buf_copy[seg * `TX_SEG_BYTES + idx - `TX_TAG_BYTES];
		endcase
	endfunction

	function automatic int byte_gap(input link_speed_e speed);
		case (speed)
			speed_10:  return 100;
			speed_100: return 10;
			default:   return 1;
		endcase
	endfunction

	// ========================================================================
	// compare
	// ========================================================================
	always @(posedge clk125MHz) begin : compare
		logic [7:0] expected;
		logic       exp_enable;
		logic       exp_ready;
		if (rst_with_vio) begin
			{checks, mismatches, other_errors} = '0;
			{exp_txid, exp_seg, exp_rep, byte_idx} = '0;
			{cyc, last_cyc} = '0;
			frame_complete = 1'b0;
			drop_due       = 1'b0;
			sent_due       = 1'b0;
		end else begin
			exp_ready = (cyc >= PHY_CYCLES);
			cyc++;
			if (phy_ready !== exp_ready) begin
				$display("FAILED at %0t: phy_ready expected %b, got %b", $time, exp_ready,
					phy_ready);
				mismatches++;
			end
			if (eth_rst_b !== exp_ready) begin
				$display("FAILED at %0t: eth_rst_b expected %b, got %b", $time, exp_ready,
					eth_rst_b);
				mismatches++;
			end
			if (!phy_ready && (tx_valid || tx_enable || tx_busy || frame_sent)) begin
				$display("error at %0t: transmit activity while the PHY is not ready", $time);
				other_errors++;
			end
			exp_enable = tx_valid || (byte_idx != 0); // high from first to last byte
			if (tx_enable !== exp_enable) begin
				$display("FAILED at %0t: tx_enable expected %b, got %b", $time, exp_enable,
					tx_enable);
				mismatches++;
			end
			if (exp_enable && tx_busy !== 1'b1) begin
				$display("FAILED at %0t: tx_busy expected 1, got %b", $time, tx_busy);
				mismatches++;
			end
			// busy drops after the last byte, frame_sent one cycle later
			if (frame_sent !== sent_due) begin
				$display("FAILED at %0t: frame_sent expected %b, got %b", $time, sent_due,
					frame_sent);
				mismatches++;
			end
			if (sent_due)
				exp_txid = (exp_txid + 1) % 256;
			sent_due = drop_due && frame_complete;
			if (drop_due) begin
				if (tx_busy !== 1'b0) begin
					$display("FAILED at %0t: tx_busy expected 0, got %b", $time, tx_busy);
					mismatches++;
				end
				drop_due       = 1'b0;
				frame_complete = 1'b0;
			end
			if (tx_valid) begin
				expected = ref_byte(exp_txid, exp_seg, exp_rep, byte_idx);
				checks++;
				if (tx_data !== expected) begin
					$display("FAILED at %0t: tx_data expected %02h, got %02h", $time,
						expected, tx_data);
					mismatches++;
				end
				if (byte_idx != 0 && cyc - last_cyc != byte_gap(link_speed)) begin
					$display("FAILED at %0t: tx_valid spacing expected %0d, got %0d", $time,
						byte_gap(link_speed), cyc - last_cyc);
					mismatches++;
				end
				last_cyc = cyc;
				byte_idx++;
				if (byte_idx == PKT_BYTES) begin
					byte_idx = 0;
					drop_due = 1'b1;
					if (exp_rep >= redundancy) begin
						exp_rep = 0;
						if (exp_seg == `TX_SEGS_PER_FRAME - 1) begin
							exp_seg        = 0;
							frame_complete = 1'b1;
						end else begin
							exp_seg++;
						end
					end else begin
						exp_rep++; // next copy of the same segment
					end
				end
			end
		end
	end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps
`include "tx_config.svh"

module tb_top
	import link_pkg::*;
();

	localparam int DEPTH         = `TX_SEGS_PER_FRAME * `TX_SEG_BYTES;
	localparam int SEED          = 91;
	localparam int PHY_TIMEOUT   = 200;
	localparam int FRAME_TIMEOUT = 20000; // a whole frame at 10M fits easily

	logic                         clk125MHz;
	logic                         rst_with_vio;
	link_speed_e                  link_speed;
	logic [7:0]                   redundancy;
	logic                         frame_done;
	logic                         wr_en;
	logic [`TX_BUF_ADDR_BITS-1:0] wr_addr;
	logic [7:0]                   wr_data;
	logic                         eth_rst_b;
	logic                         phy_ready;
	logic [7:0]                   tx_data;
	logic                         tx_valid;
	logic                         tx_enable;
	logic                         tx_busy;
	logic                         frame_sent;
	logic [DEPTH-1:0][7:0]        buf_copy; // what the buffer should hold
	logic [31:0]                  seed;
	int                           checks;
	int                           mismatches;
	int                           other_errors;
	int                           tb_errors;
	int                           timeouts;

	hdmi_eth_tx_top u_hdmi_eth_tx_top (.*);

	tx_checker u_tx_checker (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	// ========================================================================
	// frame writer and control tasks
	// ========================================================================
	task automatic fill_buffer();
		for (int a = 0; a < DEPTH; a++) begin
			@(posedge clk125MHz);
			seed = lcg_next(seed);
			wr_en       <= 1'b1;
			wr_addr     <= `TX_BUF_ADDR_BITS'(a);
			wr_data     <= seed[23:16];
			buf_copy[a] <= seed[23:16];
		end
		@(posedge clk125MHz);
		wr_en <= 1'b0;
	endtask

	task automatic wait_phy_ready();
		int n;
		n = 0;
		while (!phy_ready && n < PHY_TIMEOUT) begin
			@(negedge clk125MHz);
			n++;
		end
		if (!phy_ready) begin
			$display("timeout: phy_ready did not rise within %0d cycles", PHY_TIMEOUT);
			timeouts++;
		end
	endtask

	// the early frame_done must not start anything
	task automatic check_idle(input int cycles);
		logic busy_seen;
		busy_seen = 1'b0;
		repeat (cycles) begin
			@(negedge clk125MHz);
			busy_seen = busy_seen | tx_busy;
		end
		if (busy_seen) begin
			$display("error: a frame_done given before the PHY was ready was not dropped");
			tb_errors++;
		end
	endtask

	task automatic send_frame(input link_speed_e speed, input logic [7:0] red);
		int n;
		n = 0;
		if (timeouts == 0) begin // skip once the run has already stalled
			@(posedge clk125MHz);
			link_speed <= speed;
			redundancy <= red;
			repeat (4) @(posedge clk125MHz);
			frame_done <= 1'b1;
			@(posedge clk125MHz);
			frame_done <= 1'b0;
			@(negedge clk125MHz);
			while (!frame_sent && n < FRAME_TIMEOUT) begin
				@(negedge clk125MHz);
				n++;
			end
			if (!frame_sent) begin
				$display("timeout: frame_sent did not pulse within %0d cycles", FRAME_TIMEOUT);
				timeouts++;
			end
		end
	endtask

	// ========================================================================
	// sequence
	// ========================================================================
	initial begin
		rst_with_vio = 1'b1;
		link_speed   = speed_1000;
		redundancy   = '0;
		frame_done   = 1'b0;
		wr_en        = 1'b0;
		wr_addr      = '0;
		wr_data      = '0;
		buf_copy     = '0;
		seed         = SEED;
		tb_errors    = 0;
		timeouts     = 0;
		repeat (8) @(posedge clk125MHz);
		rst_with_vio <= 1'b0;
		@(posedge clk125MHz);
		frame_done <= 1'b1; // phy still held in reset
		@(posedge clk125MHz);
		frame_done <= 1'b0;
		wait_phy_ready();
		check_idle(20);
		fill_buffer();
		send_frame(speed_1000, 8'd0);
		fill_buffer(); // fresh payload for the next frame
		send_frame(speed_1000, 8'd2); // three copies per segment
		send_frame(speed_100, 8'd0);
		send_frame(speed_10, 8'd0);
		repeat (10) @(posedge clk125MHz);
		$display("bytes checked %0d, mismatches %0d, other errors %0d, timeouts %0d",
			checks, mismatches, other_errors + tb_errors, timeouts);
		if (mismatches + other_errors + tb_errors + timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+include
rtl/link_pkg.sv
rtl/eth_frame_pkg.sv
rtl/tx_timing.sv
rtl/send_control.sv
rtl/segment_buffer.sv
rtl/byte_data.sv
rtl/hdmi_eth_tx_top.sv
dv/tx_checker.sv
dv/tb_top.sv

// File: Bender.yml
package:
  name: hdmi_eth_tx

sources:
  - include_dirs:
      - include
    files:
      - rtl/link_pkg.sv
      - rtl/eth_frame_pkg.sv
      - rtl/tx_timing.sv
      - rtl/send_control.sv
      - rtl/segment_buffer.sv
      - rtl/byte_data.sv
      - rtl/hdmi_eth_tx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tx_checker.sv
      - dv/tb_top.sv
